//--- serialFormatPkg.sv
`default_nettype none

package serialFormatPkg;

	// channel count and channel index width.
	localparam int numChannels = 4;
	localparam int channelIdxBits = 2;

	// ------------------------------------------------------------
	// frame layout: start, data msb first, parity, stop.
	// ------------------------------------------------------------
	localparam int dataBits = 8;
	localparam int stopBits = 2;
	localparam logic idleLevel = 1'b1;

	// counter widths for the data and stop phases.
	localparam int bitCntBits = $clog2(dataBits);
	localparam int stopCntBits = $clog2(stopBits + 1);

endpackage

`default_nettype wire

//--- rxStatusPkg.sv
`default_nettype none

package rxStatusPkg;

	// receiver states.
	typedef enum logic [2:0] {
		stateIdle,
		stateStartBit,
		stateDataBits,
		stateParityBit,
		stateStopBits,
		stateFrameDone
	} rxState;

	// error field layout.
	localparam int errBits = 3;
	localparam int errBreak = 0;
	localparam int errParity = 1;
	localparam int errFraming = 2;

endpackage

`default_nettype wire

//--- lineSync.sv
`default_nettype none

module lineSync
	import serialFormatPkg::*;
(
	input  wire                    Clk,
	input  wire                    rstN,
	input  wire  [numChannels-1:0] rxIn,
	output logic [numChannels-1:0] rxSync
);

	logic [numChannels-1:0] syncStage1;

	// ------------------------------------------------------------
	// two flops per line, both reset to the idle level.
	// ------------------------------------------------------------
	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
		begin
			syncStage1 <= {numChannels{idleLevel}};
			rxSync <= {numChannels{idleLevel}};
		end
		else
		begin
			syncStage1 <= rxIn;
			rxSync <= syncStage1;
		end
	end

	// a line held low through reset shows up two cycles after release,
	// which the receivers treat as an ordinary start bit.

endmodule

`default_nettype wire

//--- rxFrameFsm.sv
`default_nettype none

module rxFrameFsm
	import serialFormatPkg::*;
	import rxStatusPkg::*;
(
	input  wire                 Clk,
	input  wire                 rstN,
	input  wire                 rxSync,
	output logic                rts,
	output logic                frameValid,
	output logic [dataBits-1:0] frameData,
	output logic [errBits-1:0]  frameError
);

	rxState state;
	rxState nextState;

	logic [dataBits-1:0] dataReg;
	logic [stopBits-1:0] stopReg;
	logic [bitCntBits-1:0] bitCnt;
	logic [stopCntBits-1:0] stopCnt;
	logic parityReg;
	logic dataXor;
	logic lastData;
	logic lastStop;
	logic stopOk;

	assign lastData = (state == stateDataBits) && (bitCnt == bitCntBits'(dataBits - 1));
	assign lastStop = (state == stateStopBits) && (stopCnt == stopCntBits'(stopBits - 1));

	// ------------------------------------------------------------
	// state machine.
	// ------------------------------------------------------------
	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= stateIdle;
		end
		else
		begin
			state <= nextState;
		end
	end

	always_comb
	begin
		nextState = state;
		case (state)
			stateIdle:
				if (rxSync != idleLevel)
					nextState = stateStartBit;
			stateStartBit:
				nextState = stateDataBits;
			stateDataBits:
				if (lastData)
					nextState = stateParityBit;
			stateParityBit:
				nextState = stateStopBits;
			stateStopBits:
				if (lastStop)
					nextState = stateFrameDone;
			stateFrameDone:
				// hold here while the line is still low, e.g. a break.
				if (rxSync == idleLevel)
					nextState = stateIdle;
			default:
				nextState = stateIdle;
		endcase
	end

	// counters and the result strobe.
	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
		begin
			bitCnt <= '0;
			stopCnt <= '0;
			frameValid <= 1'b0;
		end
		else
		begin
			frameValid <= lastStop;
			if (state == stateIdle)
			begin
				bitCnt <= '0;
				stopCnt <= '0;
			end
			else if (state == stateStartBit || state == stateDataBits)
			begin
				bitCnt <= bitCnt + 1'b1;
			end
			else if (state == stateStopBits)
			begin
				stopCnt <= stopCnt + 1'b1;
			end
		end
	end

	// ------------------------------------------------------------
	// sample registers.
	// ------------------------------------------------------------
	always_ff @(posedge Clk)
	begin
		if (state == stateStartBit || state == stateDataBits)
		begin
			dataReg <= {dataReg[dataBits-2:0], rxSync};
		end
		// first data bit seeds the running xor.
		if (state == stateStartBit)
			dataXor <= rxSync;
		else if (state == stateDataBits)
			dataXor <= dataXor ^ rxSync;
		if (state == stateParityBit)
			parityReg <= rxSync;
		if (state == stateStopBits)
		begin
			stopReg <= {stopReg[stopBits-2:0], rxSync};
		end
	end

	assign stopOk = &stopReg;

	// checks and result, only meaningful in frameDone.
	always_comb
	begin
		frameError = '0;
		frameData = '0;
		if (state == stateFrameDone)
		begin
			frameError[errBreak] = (dataReg == '0) && !stopOk;
			frameError[errParity] = (parityReg != dataXor);
			frameError[errFraming] = !stopOk;
			if (frameError == '0)
				frameData = dataReg;
		end
	end

	assign rts = (state == stateIdle);

endmodule

`default_nettype wire

//--- rxCollector.sv
`default_nettype none

module rxCollector
	import serialFormatPkg::*;
	import rxStatusPkg::*;
(
	input  wire                                  Clk,
	input  wire                                  rstN,
	input  wire  [numChannels-1:0]               frameValid,
	input  wire  [numChannels-1:0][dataBits-1:0] frameData,
	input  wire  [numChannels-1:0][errBits-1:0]  frameError,
	output logic                                 outValid,
	output logic [channelIdxBits-1:0]            outChannel,
	output logic [dataBits-1:0]                  outData,
	output logic [errBits-1:0]                   outError
);

	logic [numChannels-1:0] pending;
	logic [numChannels-1:0][dataBits-1:0] holdData;
	logic [numChannels-1:0][errBits-1:0] holdError;
	logic [channelIdxBits-1:0] lastServed;
	logic [channelIdxBits-1:0] grantIdx;
	logic grantValid;

	// ------------------------------------------------------------
	// round-robin pick, starting after the last channel served.
	// ------------------------------------------------------------
	always_comb
	begin : pickNext
		int idx;
		grantValid = 1'b0;
		grantIdx = '0;
		for (int k = 1; k <= numChannels; k++)
		begin
			idx = (int'(lastServed) + k) % numChannels;
			if (!grantValid && pending[idx])
			begin
				grantValid = 1'b1;
				grantIdx = channelIdxBits'(idx);
			end
		end
	end

	// pending flags, pointer and output strobe.
	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
		begin
			pending <= '0;
			lastServed <= channelIdxBits'(numChannels - 1);
			outValid <= 1'b0;
		end
		else
		begin
			outValid <= grantValid;
			if (grantValid)
				lastServed <= grantIdx;
			for (int i = 0; i < numChannels; i++)
			begin
				if (frameValid[i])
					pending[i] <= 1'b1;
				else if (grantValid && grantIdx == channelIdxBits'(i))
					pending[i] <= 1'b0;
			end
		end
	end

	// holding registers and output payload.
	always_ff @(posedge Clk)
	begin
		for (int i = 0; i < numChannels; i++)
		begin
			if (frameValid[i])
			begin
				holdData[i] <= frameData[i];
				holdError[i] <= frameError[i];
			end
		end
		if (grantValid)
		begin
			outChannel <= grantIdx;
			outData <= holdData[grantIdx];
			outError <= holdError[grantIdx];
		end
	end

endmodule

`default_nettype wire

//--- uartRxArray.sv
`default_nettype none

module uartRxArray
	import serialFormatPkg::*;
	import rxStatusPkg::*;
(
	input  wire                       Clk,
	input  wire                       rstN,
	input  wire  [numChannels-1:0]    rxIn,
	output logic [numChannels-1:0]    rts,
	output logic                      outValid,
	output logic [channelIdxBits-1:0] outChannel,
	output logic [dataBits-1:0]       outData,
	output logic [errBits-1:0]        outError
);

	logic [numChannels-1:0] rxSync;
	logic [numChannels-1:0] frameValid;
	logic [numChannels-1:0][dataBits-1:0] frameData;
	logic [numChannels-1:0][errBits-1:0] frameError;

	lineSync lineSync_inst (
		.Clk    (Clk),
		.rstN   (rstN),
		.rxIn   (rxIn),
		.rxSync (rxSync)
	);

	// ------------------------------------------------------------
	// one receiver per channel.
	// ------------------------------------------------------------
	for (genvar i = 0; i < numChannels; i++)
	begin : genRx
		rxFrameFsm rxFrameFsm_inst (
			.Clk        (Clk),
			.rstN       (rstN),
			.rxSync     (rxSync[i]),
			.rts        (rts[i]),
			.frameValid (frameValid[i]),
			.frameData  (frameData[i]),
			.frameError (frameError[i])
		);
	end

	rxCollector rxCollector_inst (
		.Clk        (Clk),
		.rstN       (rstN),
		.frameValid (frameValid),
		.frameData  (frameData),
		.frameError (frameError),
		.outValid   (outValid),
		.outChannel (outChannel),
		.outData    (outData),
		.outError   (outError)
	);

endmodule

`default_nettype wire

//--- tbClock.sv
`default_nettype none

module tbClock
(
	output logic Clk,
	output logic rstN
);

	localparam int halfPeriod = 2;
	localparam int resetCycles = 8;

	initial
	begin
		Clk = 1'b0;
		forever
			#halfPeriod Clk = ~Clk;
	end

	// reset lifts on the falling edge after the last reset cycle.
	initial
	begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge Clk);
		@(negedge Clk);
		rstN = 1'b1;
	end

endmodule

`default_nettype wire

//--- uartRxArrayTb.sv
`default_nettype none

module uartRxArrayTb
	import serialFormatPkg::*;
	import rxStatusPkg::*;
();

	localparam int resultTimeout = 40;
	localparam int levelTimeout = 40;
	localparam int frameLen = dataBits + stopBits + 2;

	logic Clk;
	logic rstN;
	logic [numChannels-1:0] rxIn;
	logic [numChannels-1:0] rts;
	logic outValid;
	logic [channelIdxBits-1:0] outChannel;
	logic [dataBits-1:0] outData;
	logic [errBits-1:0] outError;

	integer seed;
	int errorCount;
	int passCount;
	int failCount;

	tbClock tbClock_inst (
		.Clk  (Clk),
		.rstN (rstN)
	);

	uartRxArray uartRxArray_inst (
		.Clk        (Clk),
		.rstN       (rstN),
		.rxIn       (rxIn),
		.rts        (rts),
		.outValid   (outValid),
		.outChannel (outChannel),
		.outData    (outData),
		.outError   (outError)
	);

	// ------------------------------------------------------------
	// checking helpers.
	// ------------------------------------------------------------
	task automatic checkValue(input string name, input string field,
		input logic [31:0] expected, input logic [31:0] actual);
		assert (expected === actual)
		else
		begin
			$display("mismatch %s %s expected 0x%0h actual 0x%0h",
				name, field, expected, actual);
			errorCount++;
		end
	endtask

	task automatic checkTrue(input logic cond, input string message);
		assert (cond === 1'b1)
		else
		begin
			$display("%s", message);
			errorCount++;
		end
	endtask

	function automatic logic [errBits-1:0] errorBit(input int pos);
		logic [errBits-1:0] flag;
		flag = '0;
		flag[pos] = 1'b1;
		return flag;
	endfunction

	// start, data msb first, parity, stop bits, then the rest level.
	task automatic sendFrame(input int ch, input logic [dataBits-1:0] data, input logic parity,
		input logic [stopBits-1:0] stops, input logic restLevel);
		logic [frameLen-1:0] bits;
		bits = {1'b0, data, parity, stops};
		for (int i = frameLen - 1; i >= 0; i--)
		begin
			@(negedge Clk);
			rxIn[ch] = bits[i];
		end
		@(negedge Clk);
		rxIn[ch] = restLevel;
	endtask

	task automatic waitResult(output logic got, output logic [channelIdxBits-1:0] ch,
		output logic [dataBits-1:0] data, output logic [errBits-1:0] err);
		int cycles;
		got = 1'b0;
		ch = '0;
		data = '0;
		err = '0;
		cycles = 0;
		while (!got && cycles < resultTimeout)
		begin
			@(negedge Clk);
			cycles++;
			if (outValid === 1'b1)
			begin
				got = 1'b1;
				ch = outChannel;
				data = outData;
				err = outError;
			end
		end
	endtask

	task automatic expectResult(input string name, input int expCh,
		input logic [dataBits-1:0] expData, input logic [errBits-1:0] expErr);
		logic got;
		logic [channelIdxBits-1:0] ch;
		logic [dataBits-1:0] data;
		logic [errBits-1:0] err;
		waitResult(got, ch, data, err);
		checkTrue(got, $sformatf("%s: no result arrived within %0d cycles", name, resultTimeout));
		if (got)
		begin
			checkValue(name, "channel", expCh, ch);
			checkValue(name, "data", expData, data);
			checkValue(name, "error", expErr, err);
		end
	endtask

	task automatic expectQuiet(input string name, input int cycles);
		for (int n = 0; n < cycles; n++)
		begin
			@(negedge Clk);
			checkTrue(outValid === 1'b0,
				$sformatf("%s: an extra result appeared on channel %0d", name, outChannel));
		end
	endtask

	task automatic waitRts(input string name, input int ch, input logic level);
		int cycles;
		cycles = 0;
		while (rts[ch] !== level && cycles < levelTimeout)
		begin
			@(negedge Clk);
			cycles++;
		end
		checkTrue(rts[ch] === level,
			$sformatf("%s: rts of channel %0d never went to %0b", name, ch, level));
	endtask

	task automatic checkRtsHeld(input string name, input int ch, input int cycles);
		for (int n = 0; n < cycles; n++)
		begin
			@(negedge Clk);
			checkValue(name, $sformatf("rts[%0d]", ch), 1'b0, rts[ch]);
		end
	endtask

	task automatic finishTest(input string name, input int startErrors);
		if (errorCount == startErrors)
		begin
			passCount++;
			$display("test %s: ok", name);
		end
		else
		begin
			failCount++;
			$display("test %s: %0d errors", name, errorCount - startErrors);
		end
	endtask

	task automatic waitReset();
		int cycles;
		cycles = 0;
		while (rstN !== 1'b1 && cycles < levelTimeout)
		begin
			@(negedge Clk);
			cycles++;
		end
		checkTrue(rstN === 1'b1, "reset was never released");
		@(negedge Clk);
		checkValue("reset", "rts", {numChannels{1'b1}}, rts);
	endtask

	// ------------------------------------------------------------
	// directed tests.
	// ------------------------------------------------------------
	task automatic testCleanFrames();
		int startErrors;
		logic [dataBits-1:0] data;
		startErrors = errorCount;
		for (int c = 0; c < numChannels; c++)
		begin
			data = dataBits'($random(seed));
			sendFrame(c, data, ^data, {stopBits{1'b1}}, idleLevel);
			expectResult("clean frames", c, data, '0);
			expectQuiet("clean frames", 2 * frameLen);
		end
		finishTest("clean frames", startErrors);
	endtask

	task automatic testParityError();
		int startErrors;
		logic [dataBits-1:0] data;
		startErrors = errorCount;
		data = dataBits'($random(seed));
		sendFrame(2, data, ~^data, {stopBits{1'b1}}, idleLevel);
		expectResult("parity error", 2, '0, errorBit(errParity));
		finishTest("parity error", startErrors);
	endtask

	task automatic testFramingAndBreak();
		int startErrors;
		startErrors = errorCount;
		// second stop bit low.
		sendFrame(1, 8'ha5, ^8'ha5, 2'b10, idleLevel);
		expectResult("framing error", 1, '0, errorBit(errFraming));
		sendFrame(0, '0, 1'b0, '0, idleLevel);
		expectResult("line break", 0, '0, errorBit(errBreak) | errorBit(errFraming));
		finishTest("framing and break", startErrors);
	endtask

	task automatic testSimultaneous();
		int startErrors;
		logic [dataBits-1:0] sent [numChannels];
		logic [numChannels-1:0] seen;
		logic got;
		logic [channelIdxBits-1:0] ch;
		logic [dataBits-1:0] data;
		logic [errBits-1:0] err;
		startErrors = errorCount;
		seen = '0;
		for (int c = 0; c < numChannels; c++)
			sent[c] = dataBits'($random(seed));
		fork
			sendFrame(0, sent[0], ^sent[0], {stopBits{1'b1}}, idleLevel);
			sendFrame(1, sent[1], ^sent[1], {stopBits{1'b1}}, idleLevel);
			sendFrame(2, sent[2], ^sent[2], {stopBits{1'b1}}, idleLevel);
			sendFrame(3, sent[3], ^sent[3], {stopBits{1'b1}}, idleLevel);
		join
		// results come in any order, so match them by channel.
		for (int n = 0; n < numChannels; n++)
		begin
			waitResult(got, ch, data, err);
			checkTrue(got, $sformatf("simultaneous: result %0d did not arrive", n));
			if (got)
			begin
				checkTrue(!seen[ch], $sformatf("simultaneous: channel %0d reported twice", ch));
				seen[ch] = 1'b1;
				checkValue("simultaneous", "data", sent[ch], data);
				checkValue("simultaneous", "error", '0, err);
			end
		end
		expectQuiet("simultaneous", frameLen);
		finishTest("simultaneous", startErrors);
	endtask

	task automatic testRts();
		int startErrors;
		logic [dataBits-1:0] data;
		startErrors = errorCount;
		data = dataBits'($random(seed));
		fork
			sendFrame(3, data, ^data, {stopBits{1'b1}}, idleLevel);
			waitRts("rts", 3, 1'b0);
		join
		expectResult("rts", 3, data, '0);
		waitRts("rts", 3, 1'b1);
		// break with the line left low afterwards.
		sendFrame(1, '0, 1'b0, '0, 1'b0);
		expectResult("rts", 1, '0, errorBit(errBreak) | errorBit(errFraming));
		checkRtsHeld("rts", 1, 2 * frameLen);
		@(negedge Clk);
		rxIn[1] = idleLevel;
		waitRts("rts", 1, 1'b1);
		finishTest("rts", startErrors);
	endtask

	initial
	begin
		seed = 32'hb55d27b5;
		rxIn = {numChannels{idleLevel}};
		errorCount = 0;
		passCount = 0;
		failCount = 0;
		waitReset();
		testCleanFrames();
		testParityError();
		testFramingAndBreak();
		testSimultaneous();
		testRts();
		$display("tests passed %0d, tests failed %0d", passCount, failCount);
		if (failCount == 0 && errorCount == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- uartRxArray.f
serialFormatPkg.sv
rxStatusPkg.sv
lineSync.sv
rxFrameFsm.sv
rxCollector.sv
uartRxArray.sv
tbClock.sv
uartRxArrayTb.sv

//--- Bender.yml
package:
  name: uartRxArray

sources:
  - serialFormatPkg.sv
  - rxStatusPkg.sv
  - lineSync.sv
  - rxFrameFsm.sv
  - rxCollector.sv
  - uartRxArray.sv
  - target: test
    files:
      - tbClock.sv
      - uartRxArrayTb.sv
